// File: source/cachePkg.sv
`default_nettype none

package cachePkg;

	//////////////////////////////////////////////////
	// bus widths
	//////////////////////////////////////////////////
	localparam int AddressWidth = 32;                      // byte address on CPU and DRAM side
	localparam int DataWidth = 16;                         // one bus word

	//////////////////////////////////////////////////
	// cache geometry
	//////////////////////////////////////////////////
	localparam int NumWays = 8;                            // ways per set
	localparam int WordsPerLine = 8;                       // words per line, one DRAM burst
	localparam int LineOffsetWidth = $clog2(WordsPerLine * DataWidth / 8); // byte offset in a line

	typedef logic [AddressWidth-1:0] addressT;             // byte address
	typedef logic [DataWidth-1:0] wordT;                   // bus word
	typedef logic [DataWidth/8-1:0] byteEnableT;           // {upper, lower}, active high
	typedef logic [$clog2(WordsPerLine)-1:0] wordIndexT;   // word within a line
	typedef logic [$clog2(NumWays)-1:0] wayIndexT;         // way number
	typedef logic [NumWays-1:0] wayMaskT;                  // one bit per way

	// tree pseudo-LRU, one bit per internal node
	// bit 0 picks the half, bits 1/2 the pair, bits 3..6 the way within a pair
	typedef logic [NumWays-2:0] plruT;

endpackage

`default_nettype wire

// File: source/cacheWay.sv
`timescale 1ns/100ps
`default_nettype none

module cacheWay #(
	parameter int NumSets = 8
) (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic [$clog2(NumSets)-1:0] SetIndex,
	input wire cachePkg::wordIndexT WordIndex,
	input wire logic [cachePkg::AddressWidth-$clog2(NumSets)-cachePkg::LineOffsetWidth-1:0] LineTag,
	input wire logic TagWrite,                             // new line claimed, sets valid too
	input wire logic DataWrite,
	input wire logic ValidClear,
	input wire cachePkg::wordT FillWord,
	input wire logic Sweep,
	output logic Hit,
	output cachePkg::wordT ReadWord
);
	localparam int SetBits = $clog2(NumSets);
	localparam int TagWidth = cachePkg::AddressWidth - SetBits - cachePkg::LineOffsetWidth;

	logic [TagWidth-1:0] tagArray [NumSets];
	cachePkg::wordT dataArray [NumSets][cachePkg::WordsPerLine];
	logic [NumSets-1:0] validBits;

	//////////////////////////////////////////////////
	// read side, combinational
	//////////////////////////////////////////////////
	assign Hit = validBits[SetIndex] && (tagArray[SetIndex] == LineTag);
	assign ReadWord = dataArray[SetIndex][WordIndex];

	//////////////////////////////////////////////////
	// valid bits
	//////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			validBits <= '0;
		end else if (Sweep || ValidClear) begin
			validBits[SetIndex] <= 1'b0;                     // sweep or write invalidate
		end else if (TagWrite) begin
			validBits[SetIndex] <= 1'b1;
		end
	end

	// tag and line storage
	always_ff @(posedge Clock) begin
		if (TagWrite)
			tagArray[SetIndex] <= LineTag;
		if (DataWrite)
			dataArray[SetIndex][WordIndex] <= FillWord;      // one burst word per strobe
	end

endmodule

`default_nettype wire

// File: source/plruTree.sv
`timescale 1ns/100ps
`default_nettype none

module plruTree #(
	parameter int NumSets = 8
) (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic Sweep,                                // clear the addressed set
	input wire logic [$clog2(NumSets)-1:0] TouchSet,
	input wire logic Touch,
	input wire cachePkg::wayIndexT TouchWay,
	output cachePkg::wayIndexT Victim
);
	cachePkg::plruT treeBits [NumSets];
	cachePkg::plruT curBits;
	cachePkg::plruT touchedBits;
	logic [1:0] victimPair;                                // half and pair on the victim path

	assign curBits = treeBits[TouchSet];

	//////////////////////////////////////////////////
	// victim walk, clear bit means the lower branch
	//////////////////////////////////////////////////
	always_comb begin
		victimPair = {curBits[0], curBits[0] ? curBits[2] : curBits[1]};
		Victim = {victimPair, curBits[3 + victimPair]};
	end

	// every node on the touched path points the other way
	always_comb begin
		touchedBits = curBits;
		touchedBits[0] = ~TouchWay[2];
		if (TouchWay[2])
			touchedBits[2] = ~TouchWay[1];
		else
			touchedBits[1] = ~TouchWay[1];
		touchedBits[3 + TouchWay[2:1]] = ~TouchWay[0];
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int s = 0; s < NumSets; s++)
				treeBits[s] <= '0;
		end else if (Sweep) begin
			treeBits[TouchSet] <= '0;
		end else if (Touch) begin
			treeBits[TouchSet] <= touchedBits;               // visible the cycle after
		end
	end

endmodule

`default_nettype wire

// File: source/wayHitMerge.sv
`timescale 1ns/100ps
`default_nettype none

module wayHitMerge (
	input wire cachePkg::wayMaskT WayHit,
	input wire cachePkg::wordT WayWord [cachePkg::NumWays],
	output cachePkg::wayMaskT HitMask,
	output cachePkg::wordT HitWord,
	output cachePkg::wayIndexT HitWay
);

	assign HitMask = WayHit;                               // controller needs the raw mask for invalidation

	//////////////////////////////////////////////////
	// and-or select, safe while at most one way hits
	//////////////////////////////////////////////////
	always_comb begin
		HitWord = '0;
		HitWay = '0;
		for (int w = 0; w < cachePkg::NumWays; w++) begin
			if (WayHit[w]) begin
				HitWord = HitWord | WayWord[w];
				HitWay = HitWay | cachePkg::wayIndexT'(w);   // encoder
			end
		end
	end

	// a line is only ever claimed by one way of its set
	always_comb begin
		oneWayHits: assert final ($onehot0(WayHit))
			else $error("more than one way hit");
	end

endmodule

`default_nettype wire

// File: source/cacheController.sv
`timescale 1ns/100ps
`default_nettype none

module cacheController #(
	parameter int NumSets = 8
) (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic CpuSelect,                            // held until CpuAck
	input wire logic CpuWrite,
	input wire cachePkg::addressT CpuAddress,
	input wire cachePkg::wordT CpuWriteData,
	input wire cachePkg::byteEnableT CpuByteEnable,
	input wire cachePkg::wordT DramReadData,
	input wire logic DramReadValid,                        // one strobe per burst word
	input wire logic DramWriteAck,
	input wire cachePkg::wayMaskT HitMask,
	input wire cachePkg::wordT HitWord,
	input wire cachePkg::wayIndexT HitWay,
	input wire cachePkg::wayIndexT Victim,
	output cachePkg::wordT CpuReadData,
	output logic CpuAck,
	output logic DramReadReq,
	output logic DramWriteReq,
	output cachePkg::addressT DramAddress,
	output cachePkg::wordT DramWriteData,
	output cachePkg::byteEnableT DramByteEnable,
	output logic [$clog2(NumSets)-1:0] SetIndex,
	output cachePkg::wordIndexT WordIndex,
	output logic [cachePkg::AddressWidth-$clog2(NumSets)-cachePkg::LineOffsetWidth-1:0] LineTag,
	output cachePkg::wayMaskT TagWriteMask,
	output cachePkg::wayMaskT DataWriteMask,
	output cachePkg::wayMaskT ValidClearMask,
	output cachePkg::wordT FillWord,
	output logic Sweep,
	output logic [$clog2(NumSets)-1:0] TouchSet,
	output logic Touch,
	output cachePkg::wayIndexT TouchWay
);
	localparam int SetBits = $clog2(NumSets);
	localparam int TagWidth = cachePkg::AddressWidth - SetBits - cachePkg::LineOffsetWidth;

	typedef enum logic [2:0] {
		StSweep,
		StIdle,
		StLookup,
		StFill,
		StDeliver,
		StWriteThrough
	} stateT;

	stateT state;
	logic [SetBits-1:0] sweepCount;                        // set being invalidated
	cachePkg::wordIndexT burstCount;                       // next fill word
	cachePkg::wayIndexT victimWay;                         // way being refilled
	logic cpuAckReg;
	logic reqWrite;
	cachePkg::addressT reqAddress;                         // latched in Idle
	cachePkg::wordT reqWriteData;
	cachePkg::byteEnableT reqByteEnable;
	logic lookupHit;
	logic fillBeat;

	assign lookupHit = |HitMask;
	assign fillBeat = (state == StFill) && DramReadReq && DramReadValid; // word arriving now

	//////////////////////////////////////////////////
	// addressing of the ways and the LRU tree
	//////////////////////////////////////////////////
	assign Sweep = (state == StSweep);
	assign SetIndex = Sweep ? sweepCount : reqAddress[cachePkg::LineOffsetWidth +: SetBits];
	assign TouchSet = SetIndex;                            // tree follows the same set
	assign WordIndex = (state == StFill) ? burstCount :
		reqAddress[1 +: $bits(cachePkg::wordIndexT)];       // word within the line
	assign LineTag = reqAddress[cachePkg::AddressWidth-1 -: TagWidth];
	assign FillWord = DramReadData;

	// a read lookup touches the hit way, or the victim on a miss
	assign Touch = (state == StLookup) && !reqWrite;
	assign TouchWay = lookupHit ? HitWay : Victim;

	// read miss claims the victim: tag written and valid set in Lookup
	assign TagWriteMask = (Touch && !lookupHit) ? (cachePkg::wayMaskT'(1'b1) << Victim) : '0;
	assign DataWriteMask = fillBeat ? (cachePkg::wayMaskT'(1'b1) << victimWay) : '0;
	assign ValidClearMask = ((state == StLookup) && reqWrite) ? HitMask : '0; // no write-allocate

	//////////////////////////////////////////////////
	// DRAM and CPU side outputs
	//////////////////////////////////////////////////
	assign DramAddress = (state == StFill) ?
		{reqAddress[cachePkg::AddressWidth-1:cachePkg::LineOffsetWidth],
		{cachePkg::LineOffsetWidth{1'b0}}} : reqAddress;   // line aligned for bursts
	assign DramWriteData = reqWriteData;
	assign DramByteEnable = (state == StFill) ? '1 : reqByteEnable; // whole words on a fill
	assign CpuAck = cpuAckReg || ((state == StWriteThrough) && DramWriteAck); // write ack passes through

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= StSweep;
			sweepCount <= '0;
			burstCount <= '0;
			victimWay <= '0;
			cpuAckReg <= 1'b0;
			DramReadReq <= 1'b0;
			DramWriteReq <= 1'b0;
			reqWrite <= 1'b0;
			reqAddress <= '0;
		end else begin
			case (state)
				StSweep: begin
					sweepCount <= sweepCount + 1'b1;            // one set per cycle
					if (sweepCount == SetBits'(NumSets - 1))
						state <= StIdle;
				end
				StIdle: begin
					if (CpuSelect) begin
						reqWrite <= CpuWrite;
						reqAddress <= CpuAddress;
						state <= StLookup;
					end
				end
				StLookup: begin
					if (reqWrite) begin
						DramWriteReq <= 1'b1;                       // write-through, hit or not
						state <= StWriteThrough;
					end else if (lookupHit) begin
						state <= StDeliver;
					end else begin
						victimWay <= Victim;
						burstCount <= '0;
						state <= StFill;
					end
				end
				StFill: begin
					if (!DramReadReq) begin
						DramReadReq <= 1'b1;                        // open the burst
					end else if (DramReadValid) begin
						burstCount <= burstCount + 1'b1;            // gaps just hold the count
						if (burstCount == '1) begin
							DramReadReq <= 1'b0;                    // eighth word in
							state <= StDeliver;
						end
					end
				end
				StWriteThrough: begin
					if (DramWriteAck) begin
						DramWriteReq <= 1'b0;
						cpuAckReg <= 1'b1;                          // hold ack until select drops
						state <= StDeliver;
					end
				end
				StDeliver: begin
					if (!cpuAckReg) begin
						cpuAckReg <= 1'b1;
					end else if (!CpuSelect) begin
						cpuAckReg <= 1'b0;
						state <= StIdle;
					end
				end
				default: state <= StIdle;
			endcase
		end
	end

	// request payload and read word
	always_ff @(posedge Clock) begin
		if ((state == StIdle) && CpuSelect) begin
			reqWriteData <= CpuWriteData;
			reqByteEnable <= CpuByteEnable;
		end
		if ((state == StDeliver) && !cpuAckReg)
			CpuReadData <= HitWord;                          // line is resident by now
	end

	ackOutsideFill: assert property (@(posedge Clock) disable iff (!Reset_L)
		!(CpuAck && DramReadReq))
		else $error("CpuAck high while a line fill is open");

	// the claimed victim must already hit while its words arrive
	dataWriteInFill: assert property (@(posedge Clock) disable iff (!Reset_L)
		(|DataWriteMask) |-> ((state == StFill) && (HitMask == DataWriteMask)))
		else $error("data array written outside a line fill or into an unclaimed way");

endmodule

`default_nettype wire

// File: source/cacheTop.sv
`timescale 1ns/100ps
`default_nettype none

module cacheTop #(
	parameter int NumSets = 8
) (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic CpuSelect,
	input wire logic CpuWrite,
	input wire cachePkg::addressT CpuAddress,
	input wire cachePkg::wordT CpuWriteData,
	input wire cachePkg::byteEnableT CpuByteEnable,
	input wire cachePkg::wordT DramReadData,
	input wire logic DramReadValid,
	input wire logic DramWriteAck,
	output cachePkg::wordT CpuReadData,
	output logic CpuAck,
	output logic DramReadReq,
	output logic DramWriteReq,
	output cachePkg::addressT DramAddress,
	output cachePkg::wordT DramWriteData,
	output cachePkg::byteEnableT DramByteEnable
);
	localparam int SetBits = $clog2(NumSets);
	localparam int TagWidth = cachePkg::AddressWidth - SetBits - cachePkg::LineOffsetWidth;

	logic [SetBits-1:0] setIndex;
	logic [SetBits-1:0] touchSet;
	cachePkg::wordIndexT wordIndex;
	logic [TagWidth-1:0] lineTag;
	cachePkg::wayMaskT tagWriteMask;
	cachePkg::wayMaskT dataWriteMask;
	cachePkg::wayMaskT validClearMask;
	cachePkg::wayMaskT wayHit;
	cachePkg::wayMaskT hitMask;
	cachePkg::wordT fillWord;
	cachePkg::wordT hitWord;
	cachePkg::wordT wayWord [cachePkg::NumWays];
	logic sweep;
	logic touch;
	cachePkg::wayIndexT touchWay;
	cachePkg::wayIndexT hitWay;
	cachePkg::wayIndexT victim;

	//////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////
	cacheController #(.NumSets(NumSets)) ctrl0 (
		.Clock, .Reset_L,
		.CpuSelect, .CpuWrite, .CpuAddress, .CpuWriteData, .CpuByteEnable,
		.DramReadData, .DramReadValid, .DramWriteAck,
		.HitMask(hitMask), .HitWord(hitWord), .HitWay(hitWay), .Victim(victim),
		.CpuReadData, .CpuAck,
		.DramReadReq, .DramWriteReq, .DramAddress, .DramWriteData, .DramByteEnable,
		.SetIndex(setIndex), .WordIndex(wordIndex), .LineTag(lineTag),
		.TagWriteMask(tagWriteMask), .DataWriteMask(dataWriteMask),
		.ValidClearMask(validClearMask), .FillWord(fillWord), .Sweep(sweep),
		.TouchSet(touchSet), .Touch(touch), .TouchWay(touchWay)
	);

	// eight ways, each on its own mask bit
	for (genvar w = 0; w < cachePkg::NumWays; w++) begin : wayGen
		cacheWay #(.NumSets(NumSets)) way (
			.Clock, .Reset_L,
			.SetIndex(setIndex), .WordIndex(wordIndex), .LineTag(lineTag),
			.TagWrite(tagWriteMask[w]), .DataWrite(dataWriteMask[w]),
			.ValidClear(validClearMask[w]), .FillWord(fillWord), .Sweep(sweep),
			.Hit(wayHit[w]), .ReadWord(wayWord[w])
		);
	end

	wayHitMerge merge0 (
		.WayHit(wayHit), .WayWord(wayWord),
		.HitMask(hitMask), .HitWord(hitWord), .HitWay(hitWay)
	);

	plruTree #(.NumSets(NumSets)) lru0 (
		.Clock, .Reset_L, .Sweep(sweep),
		.TouchSet(touchSet), .Touch(touch), .TouchWay(touchWay),
		.Victim(victim)
	);

endmodule

`default_nettype wire

// File: test/dramModel.sv
`timescale 1ns/100ps
`default_nettype none

module dramModel (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic Stall,                                // hold off this cycle
	input wire logic ReadReq,
	input wire logic WriteReq,
	input wire cachePkg::addressT Address,
	input wire cachePkg::wordT WriteData,
	input wire cachePkg::byteEnableT ByteEnable,
	output cachePkg::wordT ReadData,
	output logic ReadValid,
	output logic WriteAck
);
	localparam int Depth = 4096;                           // word index is Address[12:1]

	cachePkg::wordT mem [Depth];                           // loaded by the testbench
	logic [3:0] beat;                                      // words the cache has taken
	logic [3:0] taken;

	assign taken = beat + 4'(ReadValid);                   // a strobed word is taken at the edge

	//////////////////////////////////////////////////
	// burst reads and write-through
	//////////////////////////////////////////////////
	always @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			beat <= '0;
			ReadValid <= 1'b0;
			ReadData <= '0;
			WriteAck <= 1'b0;
		end else begin
			WriteAck <= 1'b0;                               // single cycle pulse
			if (!ReadReq) begin
				beat <= '0;
				ReadValid <= 1'b0;
			end else begin
				beat <= taken;
				ReadValid <= (taken < 4'd8) && !Stall;      // gap when stalled
				ReadData <= mem[{Address[12:4], taken[2:0]}]; // line in address order
			end
			if (WriteReq && !WriteAck && !Stall) begin
				WriteAck <= 1'b1;
				if (ByteEnable[0])
					mem[Address[12:1]][7:0] <= WriteData[7:0];
				if (ByteEnable[1])
					mem[Address[12:1]][15:8] <= WriteData[15:8];
			end
		end
	end

endmodule

`default_nettype wire

// File: test/cacheTb.sv
`timescale 1ns/100ps
`default_nettype none

module cacheTb;
	localparam int NumSets = 8;
	localparam int SetBits = $clog2(NumSets);
	localparam int OffsetBits = cachePkg::LineOffsetWidth;
	localparam int TagWidth = cachePkg::AddressWidth - SetBits - OffsetBits;
	localparam logic [31:0] Seed = 32'hec7c;
	localparam int NumOps = 400;                           // random phase
	localparam int PoolTags = 16;                          // lines per pool set, twice the ways
	localparam int DirectedSet = 5;                        // outside the random pool
	localparam int DirectedLines = 9;
	localparam int Rereads = 20;
	localparam int HitLatency = 2;
	localparam int WorstCycles = 120;                      // one transaction with long gaps
	localparam int TotalOps = NumOps + DirectedLines + Rereads;
	localparam int MemDepth = 4096;
	localparam cachePkg::addressT PoolBase = 32'h4000_0000;

	logic Clock = 1'b0;
	logic Reset_L;
	logic CpuSelect;
	logic CpuWrite;
	cachePkg::addressT CpuAddress;
	cachePkg::wordT CpuWriteData;
	cachePkg::byteEnableT CpuByteEnable;
	cachePkg::wordT CpuReadData;
	logic CpuAck;
	logic DramReadReq;
	logic DramWriteReq;
	cachePkg::addressT DramAddress;
	cachePkg::wordT DramWriteData;
	cachePkg::byteEnableT DramByteEnable;
	cachePkg::wordT DramReadData;
	logic DramReadValid;
	logic DramWriteAck;
	logic dramStall;
	logic [31:0] lfsrState;

	// reference model state
	cachePkg::wordT shadow [MemDepth];
	logic [TagWidth-1:0] modelTag [NumSets][cachePkg::NumWays];
	logic modelValid [NumSets][cachePkg::NumWays];
	cachePkg::plruT modelTree [NumSets];

	cacheTop #(.NumSets(NumSets)) dut0 (
		.Clock, .Reset_L,
		.CpuSelect, .CpuWrite, .CpuAddress, .CpuWriteData, .CpuByteEnable,
		.DramReadData, .DramReadValid, .DramWriteAck,
		.CpuReadData, .CpuAck,
		.DramReadReq, .DramWriteReq, .DramAddress, .DramWriteData, .DramByteEnable
	);

	dramModel dram0 (
		.Clock, .Reset_L, .Stall(dramStall),
		.ReadReq(DramReadReq), .WriteReq(DramWriteReq), .Address(DramAddress),
		.WriteData(DramWriteData), .ByteEnable(DramByteEnable),
		.ReadData(DramReadData), .ReadValid(DramReadValid), .WriteAck(DramWriteAck)
	);

	initial begin
		forever #5 Clock = ~Clock;
	end

	initial begin
		#(TotalOps * WorstCycles * 10 + 500);
		$display("timeout: the cache stopped answering bus requests");
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	// fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = {lfsrState[30:0], lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// burst gaps and write ack delay, drawn away from the stimulus edge
	always @(negedge Clock)
		dramStall = (takeBits(1) != 0);

	//////////////////////////////////////////////////
	// failure reporting and compares
	//////////////////////////////////////////////////
	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic mismatch(input string msg);
		stopOnError($sformatf("MISMATCH at %0t ns: %s", $time, msg));
	endtask

	task automatic checkWord(input cachePkg::wordT got, input cachePkg::wordT expected,
		input string what);
		if (got !== expected)
			mismatch($sformatf("%s expected %h got %h", what, expected, got));
	endtask

	task automatic checkMiss(input bit sawBurst, input bit expectMiss);
		if (sawBurst !== expectMiss)
			mismatch($sformatf("read miss expected %0b got %0b", expectMiss, sawBurst));
	endtask

	task automatic checkAddress(input cachePkg::addressT got, input cachePkg::addressT expected,
		input string what);
		if (got !== expected)
			mismatch($sformatf("%s expected %h got %h", what, expected, got));
	endtask

	task automatic checkEnables(input cachePkg::byteEnableT got,
		input cachePkg::byteEnableT expected);
		if (got !== expected)
			mismatch($sformatf("byte enables expected %b got %b", expected, got));
	endtask

	task automatic checkLatency(input int got, input int expected);
		if (got != expected)
			mismatch($sformatf("hit latency expected %0d got %0d", expected, got));
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic cachePkg::wayIndexT victimOf(input cachePkg::plruT t);
		logic half;
		logic pair;
		half = t[0];                                       // clear means low half
		pair = half ? t[2] : t[1];
		return {half, pair, t[3 + 2 * half + pair]};
	endfunction

	function automatic cachePkg::plruT touched(input cachePkg::plruT t,
		input cachePkg::wayIndexT w);
		cachePkg::plruT r;
		r = t;
		r[0] = !w[2];                                      // every node points away from w
		r[1 + w[2]] = !w[1];
		r[3 + 2 * w[2] + w[1]] = !w[0];
		return r;
	endfunction

	task automatic modelRead(input cachePkg::addressT a, output bit miss);
		int s;
		int way;
		logic [TagWidth-1:0] t;
		s = a[OffsetBits +: SetBits];
		t = a[cachePkg::AddressWidth-1 -: TagWidth];
		way = -1;
		for (int w = 0; w < cachePkg::NumWays; w++)
			if (modelValid[s][w] && modelTag[s][w] == t)
				way = w;
		miss = (way < 0);
		if (miss) begin
			way = victimOf(modelTree[s]);
			modelTag[s][way] = t;
			modelValid[s][way] = 1'b1;
		end
		modelTree[s] = touched(modelTree[s], cachePkg::wayIndexT'(way));
	endtask

	task automatic modelWrite(input cachePkg::addressT a, input cachePkg::wordT d,
		input cachePkg::byteEnableT be);
		int s;
		logic [TagWidth-1:0] t;
		s = a[OffsetBits +: SetBits];
		t = a[cachePkg::AddressWidth-1 -: TagWidth];
		for (int w = 0; w < cachePkg::NumWays; w++)
			if (modelValid[s][w] && modelTag[s][w] == t)
				modelValid[s][w] = 1'b0;                   // no write-allocate
		if (be[0])
			shadow[a[12:1]][7:0] = d[7:0];
		if (be[1])
			shadow[a[12:1]][15:8] = d[15:8];
	endtask

	function automatic cachePkg::addressT lineAddress(input int tag, input int set, input int word);
		return PoolBase | (cachePkg::addressT'(tag) << (OffsetBits + SetBits)) |
			(cachePkg::addressT'(set) << OffsetBits) | (cachePkg::addressT'(word) << 1);
	endfunction

	//////////////////////////////////////////////////
	// one bus transaction, called right after a rising edge
	//////////////////////////////////////////////////
	task automatic runRequest(input logic write, input cachePkg::addressT a,
		input cachePkg::wordT d, input cachePkg::byteEnableT be);
		bit expectMiss;
		int edges;
		int bursts;
		logic prevReadReq;
		logic writeSeen;
		expectMiss = 1'b0;
		if (write)
			modelWrite(a, d, be);
		else
			modelRead(a, expectMiss);
		CpuWrite <= write;
		CpuAddress <= a;
		CpuWriteData <= d;
		CpuByteEnable <= be;
		CpuSelect <= 1'b1;
		edges = 0;
		bursts = 0;
		prevReadReq = 1'b0;
		writeSeen = 1'b0;
		do begin
			@(posedge Clock);
			edges++;
			if (DramReadReq && !prevReadReq) begin
				bursts++;
				checkAddress(DramAddress, a & ~cachePkg::addressT'(2 ** OffsetBits - 1),
					"fill address");
			end
			prevReadReq = DramReadReq;
			if (DramWriteReq && !writeSeen) begin
				writeSeen = 1'b1;
				checkAddress(DramAddress, a, "write address");
				checkWord(DramWriteData, d, "write data");
				checkEnables(DramByteEnable, be);
			end
		end while (!CpuAck);
		CpuSelect <= 1'b0;
		if (!write) begin
			checkMiss(bursts != 0, expectMiss);
			if (bursts > 1)
				stopOnError("a single read miss opened more than one DRAM burst");
			checkWord(CpuReadData, shadow[a[12:1]], "read data");
			if (!expectMiss)
				checkLatency(edges - 2, HitLatency);       // select seen one edge late, ack one edge late
		end else if (!writeSeen) begin
			stopOnError("write acknowledged without a DRAM write request");
		end
		@(posedge Clock);                                  // select low for one cycle
	endtask

	task automatic randomOp();
		logic write;
		cachePkg::addressT a;
		cachePkg::wordT d;
		cachePkg::byteEnableT be;
		write = (takeBits(2) == 0);                        // about one write in four
		a = lineAddress(int'(takeBits($clog2(PoolTags))), int'(takeBits(1)), int'(takeBits(3)));
		d = cachePkg::wordT'(takeBits(16));
		be = cachePkg::byteEnableT'(takeBits(2));
		if (be == 2'b00)
			be = 2'b11;
		runRequest(write, a, d, be);
	endtask

	initial begin
		lfsrState = Seed;
		dramStall = 1'b0;
		Reset_L = 1'b0;
		CpuSelect = 1'b0;
		CpuWrite = 1'b0;
		CpuAddress = '0;
		CpuWriteData = '0;
		CpuByteEnable = '0;
		for (int i = 0; i < MemDepth; i++) begin
			shadow[i] = 16'(i * 40503) ^ 16'(i >> 5) ^ 16'h3c5a;
			dram0.mem[i] = shadow[i];
		end
		for (int s = 0; s < NumSets; s++) begin
			modelTree[s] = '0;
			for (int w = 0; w < cachePkg::NumWays; w++) begin
				modelValid[s][w] = 1'b0;
				modelTag[s][w] = '0;
			end
		end
		repeat (10) @(posedge Clock);
		Reset_L <= 1'b1;
		repeat (NumSets + 4) @(posedge Clock);             // invalidate sweep

		// nine lines into one set, then re-reads in LFSR order
		for (int i = 0; i < DirectedLines; i++)
			runRequest(1'b0, lineAddress(32 + i, DirectedSet, i % 8), '0, 2'b11);
		for (int i = 0; i < Rereads; i++)
			runRequest(1'b0, lineAddress(32 + int'(takeBits(4)) % DirectedLines, DirectedSet,
				int'(takeBits(3))), '0, 2'b11);

		for (int op = 0; op < NumOps; op++)
			randomOp();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
source/cachePkg.sv
source/cacheWay.sv
source/plruTree.sv
source/wayHitMerge.sv
source/cacheController.sv
source/cacheTop.sv
test/dramModel.sv
test/cacheTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = cacheTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log
BIN       = $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "run ended without passing"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
